// ==== design/irq_arbiter.sv ====
// Fixed-priority interrupt arbiter.
// Order is 31 down to 16, then 11, 3 and 7. Issues a registered one-cycle
// acknowledge with the winning id, once per winner.

`include "irq_settings.svh"

module irq_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  irq_pkg::csr_state_t  csr_i,
  input  irq_pkg::priv_lvl_e   priv_lvl_i,
  output irq_pkg::irq_ack_t    irq_ack_o
);

  logic [`IRQ_NUM-1:0]  pending;
  logic                 win_valid;
  logic [`IRQ_ID_W-1:0] win_id;
  logic                 global_en;
  logic                 ack_q;
  logic [`IRQ_ID_W-1:0] id_q;
  logic                 last_valid_q;
  logic [`IRQ_ID_W-1:0] last_id_q;
  logic                 fire;

  assign pending = csr_i.mip & csr_i.mie;

  // --------------------
  // Priority select
  // --------------------
  // Later assignments override earlier ones, so lowest priority goes first
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pending[7]) begin
      win_valid = 1'b1;
      win_id    = `IRQ_ID_W'(7);
    end
    if (pending[3]) begin
      win_valid = 1'b1;
      win_id    = `IRQ_ID_W'(3);
    end
    if (pending[11]) begin
      win_valid = 1'b1;
      win_id    = `IRQ_ID_W'(11);
    end
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pending[i]) begin
        win_valid = 1'b1;
        win_id    = `IRQ_ID_W'(i);
      end
    end
  end

  // U mode always takes machine interrupts
  assign global_en = ((priv_lvl_i == irq_pkg::PRIV_LVL_M) && csr_i.mstatus_mie) ||
                     (priv_lvl_i == irq_pkg::PRIV_LVL_U);

  // New winner only, and never two acks back to back
  assign fire = win_valid && global_en && !ack_q &&
                !(last_valid_q && (last_id_q == win_id));

  // --------------------
  // Ack and winner history
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q        <= 1'b0;
      id_q         <= '0;
      last_valid_q <= 1'b0;
      last_id_q    <= '0;
    end else begin
      ack_q <= fire;
      if (fire) begin
        id_q         <= win_id;
        last_valid_q <= 1'b1;
        last_id_q    <= win_id;
      end else if (!win_valid) begin
        last_valid_q <= 1'b0;
      end
    end
  end

  assign irq_ack_o.ack = ack_q;
  assign irq_ack_o.id  = id_q;

endmodule

// ==== design/irq_csr_regs.sv ====
// Interrupt CSR block behind a Wishbone classic slave.
// Holds the registered mip, the mie enables and the mstatus MIE/TW bits.
// Every access is acked one cycle after the strobe and the slave never stalls.

`include "irq_settings.svh"

module irq_csr_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`IRQ_NUM-1:0]   irq_i,
  input  irq_pkg::wb_req_t      wb_req_i,
  output irq_pkg::wb_rsp_t      wb_rsp_o,
  output irq_pkg::csr_state_t   csr_o
);

  logic [`IRQ_NUM-1:0] mip_q;
  logic [`IRQ_NUM-1:0] mie_q;
  logic                mstatus_mie_q;
  logic                mstatus_tw_q;
  logic                ack_q;
  logic [31:0]         rdata_q;
  logic                access;
  logic [31:0]         rdata_d;

  // New access seen while no ack is out
  assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  // --------------------
  // Read mux
  // --------------------
  always_comb begin
    rdata_d = '0;
    case (wb_req_i.adr)
      `WB_ADR_W'(`CSR_MIP_OFS): rdata_d = mip_q;
      `WB_ADR_W'(`CSR_MIE_OFS): rdata_d = mie_q;
      `WB_ADR_W'(`CSR_MSTATUS_OFS): begin
        rdata_d[`MSTATUS_MIE_BIT] = mstatus_mie_q;
        rdata_d[`MSTATUS_TW_BIT]  = mstatus_tw_q;
      end
      default: rdata_d = '0;
    endcase
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q         <= '0;
      mie_q         <= '0;
      mstatus_mie_q <= 1'b0;
      mstatus_tw_q  <= 1'b0;
      ack_q         <= 1'b0;
    end else begin
      // mip follows the lines one cycle late and reserved lines never show
      mip_q <= irq_i & `IRQ_VALID_MASK;
      ack_q <= access;
      if (access && wb_req_i.we) begin
        if (wb_req_i.adr == `WB_ADR_W'(`CSR_MIE_OFS)) begin
          mie_q <= wb_req_i.dat & `IRQ_VALID_MASK;
        end
        if (wb_req_i.adr == `WB_ADR_W'(`CSR_MSTATUS_OFS)) begin
          mstatus_mie_q <= wb_req_i.dat[`MSTATUS_MIE_BIT];
          mstatus_tw_q  <= wb_req_i.dat[`MSTATUS_TW_BIT];
        end
      end
    end
  end

  // Read data goes out together with ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

  assign csr_o.mip         = mip_q;
  assign csr_o.mie         = mie_q;
  assign csr_o.mstatus_mie = mstatus_mie_q;
  assign csr_o.mstatus_tw  = mstatus_tw_q;

endmodule

// ==== design/irq_pkg.sv ====
// Types shared by the interrupt and sleep unit.
// Modules refer to these by scoped name, e.g. irq_pkg::wb_req_t.

`include "irq_settings.svh"

package irq_pkg;

  // Privilege levels seen by the unit
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // --------------------
  // Wishbone classic
  // --------------------
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`WB_ADR_W-1:0]  adr;
    logic [31:0]           dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // --------------------
  // Core side
  // --------------------
  typedef struct packed {
    logic [`IRQ_NUM-1:0] mip;
    logic [`IRQ_NUM-1:0] mie;
    logic                mstatus_mie;
    logic                mstatus_tw;
  } csr_state_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    logic        err;
    logic        kill;
  } wb_stage_t;

  typedef struct packed {
    logic [`OUTSTANDING_W-1:0] instr_outstanding;
    logic [`OUTSTANDING_W-1:0] data_outstanding;
    logic                      instr_req;
    logic                      data_req;
  } bus_status_t;

  typedef struct packed {
    logic                 ack;
    logic [`IRQ_ID_W-1:0] id;
  } irq_ack_t;

endpackage

// ==== design/irq_settings.svh ====
// Shared constants of the interrupt and sleep unit.
// Included by the package, the RTL and the testbench. Change values here only.

`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// Interrupt lines
`define IRQ_NUM 32
`define IRQ_VALID_MASK 32'hffff_0888
`define IRQ_ID_W 5

// WFI decode and sleep entry
`define WFI_INSTR 32'h10500073
`define SLEEP_ENTRY_DELAY 2

// CSR word offsets on the Wishbone port
`define CSR_MIP_OFS 0
`define CSR_MIE_OFS 1
`define CSR_MSTATUS_OFS 2

// mstatus bit positions
`define MSTATUS_MIE_BIT 3
`define MSTATUS_TW_BIT 21

// Bus widths
`define WB_ADR_W 2
`define OUTSTANDING_W 2

`endif

// ==== design/irq_sleep_unit.sv ====
// Top level of the interrupt and sleep unit.
// Ties the CSR block, the arbiter, the WFI detector and the sleep
// controller together and exposes the core-facing ports.

`include "irq_settings.svh"

module irq_sleep_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`IRQ_NUM-1:0]   irq_i,
  input  irq_pkg::priv_lvl_e    priv_lvl_i,
  input  irq_pkg::wb_req_t      wb_req_i,
  output irq_pkg::wb_rsp_t      wb_rsp_o,
  input  irq_pkg::wb_stage_t    wb_stage_i,
  input  irq_pkg::bus_status_t  bus_i,
  input  logic                  debug_req_i,
  output logic                  irq_ack_o,
  output logic [`IRQ_ID_W-1:0]  irq_id_o,
  output logic                  core_sleep_o,
  output logic                  wfi_retire_o
);

  irq_pkg::csr_state_t csr;
  irq_pkg::irq_ack_t   irq_ack;
  logic                in_wb;
  logic [1:0]          age;

  irq_csr_regs csr_regs_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .irq_i    (irq_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .csr_o    (csr)
  );

  irq_arbiter arbiter_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .csr_i      (csr),
    .priv_lvl_i (priv_lvl_i),
    .irq_ack_o  (irq_ack)
  );

  wfi_detector wfi_detector_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_stage_i (wb_stage_i),
    .priv_lvl_i (priv_lvl_i),
    .csr_i      (csr),
    .in_wb_o    (in_wb),
    .age_o      (age)
  );

  sleep_controller sleep_controller_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .irq_i        (irq_i),
    .csr_i        (csr),
    .debug_req_i  (debug_req_i),
    .bus_i        (bus_i),
    .in_wb_i      (in_wb),
    .age_i        (age),
    .core_sleep_o (core_sleep_o),
    .wfi_retire_o (wfi_retire_o)
  );

  assign irq_ack_o = irq_ack.ack;
  assign irq_id_o  = irq_ack.id;

endmodule

// ==== design/sleep_controller.sv ====
// Sleep state for a WFI sitting in writeback.
// Enters sleep once the WFI is old enough and the buses are idle, leaves on
// a pending enabled interrupt or a debug request, and retires the WFI then.

`include "irq_settings.svh"

module sleep_controller (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [`IRQ_NUM-1:0]  irq_i,
  input  irq_pkg::csr_state_t  csr_i,
  input  logic                 debug_req_i,
  input  irq_pkg::bus_status_t bus_i,
  input  logic                 in_wb_i,
  input  logic [1:0]           age_i,
  output logic                 core_sleep_o,
  output logic                 wfi_retire_o
);

  logic [`IRQ_NUM-1:0]       irq_q;
  logic [`OUTSTANDING_W-1:0] instr_out_q;
  logic [`OUTSTANDING_W-1:0] data_out_q;
  logic                      blocked;
  logic                      wake;
  logic                      sleep_q;

  // --------------------
  // Conditions
  // --------------------
  // Outstanding counts also block for one cycle after they drain
  assign blocked = (|bus_i.instr_outstanding) || (|instr_out_q) ||
                   (|bus_i.data_outstanding) || (|data_out_q) ||
                   bus_i.instr_req || bus_i.data_req;

  assign wake = (|(irq_q & csr_i.mie)) || debug_req_i;

  // --------------------
  // State
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q       <= '0;
      instr_out_q <= '0;
      data_out_q  <= '0;
      sleep_q     <= 1'b0;
    end else begin
      irq_q       <= irq_i;
      instr_out_q <= bus_i.instr_outstanding;
      data_out_q  <= bus_i.data_outstanding;
      if (!in_wb_i || blocked || wake) begin
        sleep_q <= 1'b0;
      end else if (age_i >= 2'(`SLEEP_ENTRY_DELAY)) begin
        sleep_q <= 1'b1;
      end
    end
  end

  assign core_sleep_o = sleep_q;

  // WFI cannot retire in its first writeback cycle
  assign wfi_retire_o = in_wb_i && (age_i >= 2'd1) && wake;

endmodule

// ==== design/wfi_detector.sv ====
// WFI detection in the writeback stage.
// Flags a legal, not invalidated WFI and reports how many cycles it has
// already spent there, saturating at 3.

`include "irq_settings.svh"

module wfi_detector (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  irq_pkg::wb_stage_t   wb_stage_i,
  input  irq_pkg::priv_lvl_e   priv_lvl_i,
  input  irq_pkg::csr_state_t  csr_i,
  output logic                 in_wb_o,
  output logic [1:0]           age_o
);

  logic       trapped;
  logic       in_wb;
  logic [1:0] age_q;

  // TW turns WFI into an illegal instruction in U mode
  assign trapped = (priv_lvl_i == irq_pkg::PRIV_LVL_U) && csr_i.mstatus_tw;

  assign in_wb = wb_stage_i.valid &&
                 (wb_stage_i.rdata == `WFI_INSTR) &&
                 !wb_stage_i.err &&
                 !wb_stage_i.kill &&
                 !trapped;

  // --------------------
  // Age counter
  // --------------------
  // Zero in the first cycle, then counts while the WFI stays put
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      age_q <= '0;
    end else if (!in_wb) begin
      age_q <= '0;
    end else if (age_q != 2'd3) begin
      age_q <= age_q + 2'd1;
    end
  end

  assign in_wb_o = in_wb;
  assign age_o   = in_wb ? age_q : 2'd0;

endmodule

// ==== project.f ====
+incdir+design
design/irq_pkg.sv
design/irq_csr_regs.sv
design/irq_arbiter.sv
design/wfi_detector.sv
design/sleep_controller.sv
design/irq_sleep_unit.sv
verification/irq_sleep_unit_tb.sv

// ==== verification/irq_sleep_unit_tb.sv ====
// Directed testbench for the interrupt and sleep unit.
// Drives CSR accesses over Wishbone, interrupt lines, a WFI in writeback and
// the bus status, and checks acks, ids, sleep entry, blocking and wake.

`include "irq_settings.svh"

module irq_sleep_unit_tb;

  // Longest test sequence is a few hundred cycles
  localparam int WATCHDOG_CYCLES = 2000;

  logic                  clk_i;
  logic                  rst_ni;
  logic [`IRQ_NUM-1:0]   irq_i;
  irq_pkg::priv_lvl_e    priv_lvl_i;
  irq_pkg::wb_req_t      wb_req;
  irq_pkg::wb_rsp_t      wb_rsp;
  irq_pkg::wb_stage_t    wb_stage;
  irq_pkg::bus_status_t  bus;
  logic                  debug_req_i;
  logic                  irq_ack_o;
  logic [`IRQ_ID_W-1:0]  irq_id_o;
  logic                  core_sleep_o;
  logic                  wfi_retire_o;
  int                    errors;
  int                    checks;
  logic [31:0]           rd;

  irq_sleep_unit irq_sleep_unit_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .irq_i        (irq_i),
    .priv_lvl_i   (priv_lvl_i),
    .wb_req_i     (wb_req),
    .wb_rsp_o     (wb_rsp),
    .wb_stage_i   (wb_stage),
    .bus_i        (bus),
    .debug_req_i  (debug_req_i),
    .irq_ack_o    (irq_ack_o),
    .irq_id_o     (irq_id_o),
    .core_sleep_o (core_sleep_o),
    .wfi_retire_o (wfi_retire_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired before the tests finished");
    $display("Testbench failed");
    $finish;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // Reference priority order: 31..16, then 11, 3, 7
  function automatic logic [`IRQ_ID_W-1:0] expected_winner(input logic [31:0] pend);
    int order [19];
    bit found;
    found           = 1'b0;
    expected_winner = '0;
    for (int k = 0; k < 16; k++) begin
      order[k] = 31 - k;
    end
    order[16] = 11;
    order[17] = 3;
    order[18] = 7;
    // First listed line that is pending wins
    for (int k = 0; k < 19; k++) begin
      if (!found && pend[order[k]]) begin
        expected_winner = `IRQ_ID_W'(order[k]);
        found           = 1'b1;
      end
    end
  endfunction

  task automatic wb_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int waited;
    waited = 0;
    @(negedge clk_i);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!wb_rsp.ack && waited < 8);
    checks++;
    assert (wb_rsp.ack) else begin
      errors++;
      $display("Wishbone access at offset %0d got no ack at %0t", adr, $time);
    end
    rdat   = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic wb_write(input int ofs, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, `WB_ADR_W'(ofs), dat, unused);
  endtask

  task automatic wb_read(input int ofs, output logic [31:0] dat);
    wb_access(1'b0, `WB_ADR_W'(ofs), 32'h0, dat);
  endtask

  task automatic expect_sleep_low(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_val("core_sleep_o", 0, core_sleep_o);
    end
  endtask

  task automatic drive_wfi(input logic kill);
    @(negedge clk_i);
    wb_stage.valid = 1'b1;
    wb_stage.rdata = `WFI_INSTR;
    wb_stage.err   = 1'b0;
    wb_stage.kill  = kill;
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_csr_access();
    wb_write(`CSR_MIE_OFS, 32'hffff_ffff);
    wb_read(`CSR_MIE_OFS, rd);
    check_val("mie", `IRQ_VALID_MASK, rd);
    wb_write(`CSR_MSTATUS_OFS, 32'hffff_ffff);
    wb_read(`CSR_MSTATUS_OFS, rd);
    check_val("mstatus", (32'h1 << `MSTATUS_MIE_BIT) | (32'h1 << `MSTATUS_TW_BIT), rd);
    wb_write(`CSR_MIP_OFS, 32'hffff_ffff);
    @(negedge clk_i) irq_i = 32'h5a5a_f0f0;
    wb_read(`CSR_MIP_OFS, rd);
    check_val("mip", 32'h5a5a_f0f0 & `IRQ_VALID_MASK, rd);
    @(negedge clk_i) irq_i = '0;
    repeat (3) @(negedge clk_i);
  endtask

  task automatic test_priority();
    logic [31:0]          pat;
    logic [`IRQ_ID_W-1:0] exp_id;
    wb_write(`CSR_MIE_OFS, 32'hffff_ffff);
    wb_write(`CSR_MSTATUS_OFS, 32'h1 << `MSTATUS_MIE_BIT);
    for (int n = 0; n < 12; n++) begin
      pat = $urandom & `IRQ_VALID_MASK;
      // Some patterns keep only the low lines so 11, 3 and 7 compete
      if (n % 4 == 1) pat = (pat & 32'h0000_00ff) | 32'h80;
      if (n % 4 == 3) pat = (pat & 32'h0000_0fff) | 32'h08;
      if (pat == 0) pat = 32'h8;
      exp_id = expected_winner(pat);
      @(negedge clk_i) irq_i = pat;
      @(negedge clk_i) check_val("irq_ack_o", 0, irq_ack_o);
      @(negedge clk_i);
      check_val("irq_ack_o", 1, irq_ack_o);
      check_val("irq_id_o", exp_id, irq_id_o);
      // Same winner held, so no second ack
      repeat (3) begin
        @(negedge clk_i) check_val("irq_ack_o", 0, irq_ack_o);
      end
      @(negedge clk_i) irq_i = '0;
      repeat (3) @(negedge clk_i);
    end
  endtask

  task automatic test_global_enable();
    logic seen;
    wb_write(`CSR_MSTATUS_OFS, 32'h0);
    @(negedge clk_i) irq_i = 32'h1 << 16;
    repeat (5) begin
      @(negedge clk_i) check_val("irq_ack_o", 0, irq_ack_o);
    end
    seen = 1'b0;
    priv_lvl_i = irq_pkg::PRIV_LVL_U;
    repeat (4) begin
      @(negedge clk_i) if (irq_ack_o) seen = 1'b1;
    end
    checks++;
    assert (seen) else begin
      errors++;
      $display("No interrupt ack in U mode with MIE clear at %0t", $time);
    end
    irq_i      = '0;
    priv_lvl_i = irq_pkg::PRIV_LVL_M;
    repeat (3) @(negedge clk_i);
    wb_write(`CSR_MSTATUS_OFS, 32'h1 << `MSTATUS_MIE_BIT);
    wb_write(`CSR_MIE_OFS, ~(32'h1 << 16));
    @(negedge clk_i) irq_i = 32'h1 << 16;
    repeat (5) begin
      @(negedge clk_i) check_val("irq_ack_o", 0, irq_ack_o);
    end
    irq_i = '0;
    wb_write(`CSR_MIE_OFS, 32'hffff_ffff);
    wb_write(`CSR_MSTATUS_OFS, 32'h0);
  endtask

  task automatic test_sleep_entry();
    drive_wfi(1'b0);
    expect_sleep_low(2);
    @(negedge clk_i) check_val("core_sleep_o", 1, core_sleep_o);
    // Asleep without a wake source, so the WFI stays unretired
    check_val("wfi_retire_o", 0, wfi_retire_o);
    wb_stage = '0;
    expect_sleep_low(2);
    // WFI traps in U mode with TW set
    wb_write(`CSR_MSTATUS_OFS, 32'h1 << `MSTATUS_TW_BIT);
    priv_lvl_i = irq_pkg::PRIV_LVL_U;
    drive_wfi(1'b0);
    expect_sleep_low(6);
    wb_stage   = '0;
    priv_lvl_i = irq_pkg::PRIV_LVL_M;
    wb_write(`CSR_MSTATUS_OFS, 32'h0);
    drive_wfi(1'b1);
    expect_sleep_low(6);
    wb_stage = '0;
  endtask

  task automatic test_block_and_wake();
    logic seen;
    drive_wfi(1'b0);
    bus.instr_outstanding = 2'd1;
    expect_sleep_low(6);
    bus  = '0;
    seen = 1'b0;
    repeat (5) begin
      @(negedge clk_i) if (core_sleep_o) seen = 1'b1;
    end
    checks++;
    assert (seen) else begin
      errors++;
      $display("Sleep not entered after outstanding bus traffic drained at %0t", $time);
    end
    irq_i = 32'h1 << 16;
    @(negedge clk_i);
    check_val("wfi_retire_o", 1, wfi_retire_o);
    check_val("core_sleep_o", 1, core_sleep_o);
    @(negedge clk_i) check_val("core_sleep_o", 0, core_sleep_o);
    irq_i    = '0;
    wb_stage = '0;
    repeat (3) @(negedge clk_i);
    drive_wfi(1'b0);
    repeat (3) @(negedge clk_i);
    check_val("core_sleep_o", 1, core_sleep_o);
    debug_req_i = 1'b1;
    @(negedge clk_i);
    check_val("core_sleep_o", 0, core_sleep_o);
    check_val("wfi_retire_o", 1, wfi_retire_o);
    debug_req_i = 1'b0;
    wb_stage    = '0;
    repeat (3) @(negedge clk_i);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    errors      = 0;
    checks      = 0;
    rst_ni      = 1'b0;
    irq_i       = '0;
    priv_lvl_i  = irq_pkg::PRIV_LVL_M;
    wb_req      = '0;
    wb_stage    = '0;
    bus         = '0;
    debug_req_i = 1'b0;
    rd          = $urandom(32'h84b9);
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("irq_ack_o", 0, irq_ack_o);
    check_val("core_sleep_o", 0, core_sleep_o);
    check_val("wfi_retire_o", 0, wfi_retire_o);
    check_val("wb_ack", 0, wb_rsp.ack);
    test_csr_access();
    test_priority();
    test_global_enable();
    test_sleep_entry();
    test_block_and_wake();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
